//--- common/pool_geom_pkg.sv
//==========================================================================
// Geometry of the max-pooling engine
// Widths of indices, activations and counters, and the default core count.
// Imported by the bus package and by every RTL block.
//==========================================================================
package pool_geom_pkg;

    // Point index and memory address
    localparam int IDX_WIDTH    = 16;

    // One activation, and activations per feature row
    localparam int ACT_WIDTH    = 8;
    localparam int LANES        = 8;

    // Largest neighbour count, all of them held in one map word
    localparam int MAX_K        = 8;
    localparam int K_WIDTH      = 4;

    // Channel groups per point
    localparam int GRP_WIDTH    = 8;

    // Default number of pool cores
    localparam int NUM_CORE_DEF = 4;

endpackage

//--- common/pool_bus_pkg.sv
//==========================================================================
// Data types carried on the map, feature and write buses
// Widths come from the geometry package.
//==========================================================================
package pool_bus_pkg;

    import pool_geom_pkg::*;

    // One point index or memory address
    typedef logic [IDX_WIDTH-1:0] idx_t;

    // One feature row, lane 0 in the low bits
    typedef logic [LANES-1:0][ACT_WIDTH-1:0] act_row_t;

    // All neighbour indices of one point, index 0 in the low bits
    typedef logic [MAX_K-1:0][IDX_WIDTH-1:0] map_word_t;

endpackage

//--- common/core_port_if.sv
//==========================================================================
// Link between one pool core and one port of a core arbiter
// A request moves when req_vld and req_rdy are high together.
// rsp_vld is a single-cycle strobe that carries rsp_dat back to the core.
//==========================================================================
`timescale 1ns/1ns

interface core_port_if #(
    parameter int DAT_WIDTH = 128
) ();

    import pool_bus_pkg::*;

    // Request, held stable until accepted
    logic                 req_vld;
    idx_t                 req_addr;
    logic [DAT_WIDTH-1:0] req_dat;
    logic                 req_rdy;

    // Reply routed back by the arbiter
    logic                 rsp_vld;
    logic [DAT_WIDTH-1:0] rsp_dat;

    modport core (
        output req_vld, req_addr, req_dat,
        input  req_rdy, rsp_vld, rsp_dat
    );

    modport arb (
        input  req_vld, req_addr, req_dat,
        output req_rdy, rsp_vld, rsp_dat
    );

endinterface

//--- pool_core/lane_max.sv
//==========================================================================
// Running lane-wise maximum over the feature rows of one channel group
// load starts a new group with neighbour 0, update folds in later rows.
//==========================================================================
`timescale 1ns/1ns

module lane_max (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic                   update,
    input  pool_bus_pkg::act_row_t row_in,
    output pool_bus_pkg::act_row_t row_max
);

    import pool_geom_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_max <= '0;
        end else if (load) begin
            row_max <= row_in;
        end else if (update) begin
            // Unsigned compare, lane by lane
            for (int i = 0; i < LANES; i++) begin
                if (row_in[i] > row_max[i]) begin
                    row_max[i] <= row_in[i];
                end
            end
        end
    end

endmodule

//--- pool_core/pool_core.sv
//==========================================================================
// Pool core sequencer
// Walks the configured points, channel groups and neighbours. Per point it
// fetches one map word, per group it reads K feature rows into lane_max and
// then offers the pooled row on the write port. One request in flight.
//==========================================================================
`timescale 1ns/1ns

module pool_core (
    input  logic                                clk,
    input  logic                                rst_n,
    // Configuration handshake
    input  logic                                cfg_vld,
    output logic                                cfg_rdy,
    input  logic [pool_geom_pkg::K_WIDTH-1:0]   cfg_k,
    input  pool_bus_pkg::idx_t                  cfg_num_points,
    input  logic [pool_geom_pkg::GRP_WIDTH-1:0] cfg_num_grp,
    input  pool_bus_pkg::idx_t                  cfg_out_base,
    // Shared map and write paths
    core_port_if.core                           map_port,
    core_port_if.core                           wr_port,
    // Private feature read port
    output logic                                ofm_rd_vld,
    output pool_bus_pkg::idx_t                  ofm_rd_addr,
    input  logic                                ofm_rd_rdy,
    input  logic                                ofm_rd_dat_vld,
    input  pool_bus_pkg::act_row_t              ofm_rd_dat
);

    import pool_geom_pkg::*;
    import pool_bus_pkg::*;

    //======================================================================
    // State encoding
    //======================================================================
    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_MAP_REQ   = 3'd1;
    localparam logic [2:0] S_MAP_WAIT  = 3'd2;
    localparam logic [2:0] S_FEAT_REQ  = 3'd3;
    localparam logic [2:0] S_FEAT_WAIT = 3'd4;
    localparam logic [2:0] S_WRITE     = 3'd5;

    logic [2:0]           state;

    // Latched configuration
    logic [K_WIDTH-1:0]   k_q;
    idx_t                 num_points_q;
    logic [GRP_WIDTH-1:0] num_grp_q;
    idx_t                 out_base_q;

    // Loop counters and the current point's neighbours
    idx_t                 pt_cnt;
    logic [GRP_WIDTH-1:0] grp_cnt;
    logic [K_WIDTH-1:0]   nb_cnt;
    map_word_t            map_word;
    act_row_t             row_max;

    logic                 cfg_hs;
    logic                 map_hs;
    logic                 map_rsp;
    logic                 feat_hs;
    logic                 row_strb;
    logic                 wr_hs;
    logic                 last_nb;
    logic                 last_grp;
    logic                 last_pt;

    //======================================================================
    // Handshakes and addresses
    //======================================================================
    assign cfg_rdy  = (state == S_IDLE);
    assign cfg_hs   = cfg_vld && cfg_rdy;
    assign map_hs   = map_port.req_vld && map_port.req_rdy;
    assign map_rsp  = (state == S_MAP_WAIT) && map_port.rsp_vld;
    assign feat_hs  = ofm_rd_vld && ofm_rd_rdy;
    assign row_strb = (state == S_FEAT_WAIT) && ofm_rd_dat_vld;
    assign wr_hs    = wr_port.req_vld && wr_port.req_rdy;

    assign last_nb  = (nb_cnt == k_q - 1'b1);
    assign last_grp = (grp_cnt == num_grp_q - 1'b1);
    assign last_pt  = (pt_cnt == num_points_q - 1'b1);

    // One map word per point
    assign map_port.req_vld  = (state == S_MAP_REQ);
    assign map_port.req_addr = pt_cnt;
    assign map_port.req_dat  = '0;

    // Feature row of the current neighbour and group
    assign ofm_rd_vld  = (state == S_FEAT_REQ);
    assign ofm_rd_addr = map_word[nb_cnt] * num_grp_q + grp_cnt;

    // Pooled row goes to the configured output area
    assign wr_port.req_vld  = (state == S_WRITE);
    assign wr_port.req_addr = out_base_q + pt_cnt * num_grp_q + grp_cnt;
    assign wr_port.req_dat  = row_max;

    //======================================================================
    // Sequencer
    //======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            pt_cnt  <= '0;
            grp_cnt <= '0;
            nb_cnt  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cfg_hs) begin
                        state   <= S_MAP_REQ;
                        pt_cnt  <= '0;
                        grp_cnt <= '0;
                        nb_cnt  <= '0;
                    end
                end
                S_MAP_REQ: begin
                    if (map_hs) begin
                        state <= S_MAP_WAIT;
                    end
                end
                S_MAP_WAIT: begin
                    if (map_rsp) begin
                        state <= S_FEAT_REQ;
                    end
                end
                S_FEAT_REQ: begin
                    if (feat_hs) begin
                        state <= S_FEAT_WAIT;
                    end
                end
                S_FEAT_WAIT: begin
                    if (row_strb) begin
                        if (last_nb) begin
                            state <= S_WRITE;
                        end else begin
                            nb_cnt <= nb_cnt + 1'b1;
                            state  <= S_FEAT_REQ;
                        end
                    end
                end
                S_WRITE: begin
                    // Stalls here under write back-pressure
                    if (wr_hs) begin
                        nb_cnt <= '0;
                        if (!last_grp) begin
                            grp_cnt <= grp_cnt + 1'b1;
                            state   <= S_FEAT_REQ;
                        end else if (last_pt) begin
                            grp_cnt <= '0;
                            state   <= S_IDLE;
                        end else begin
                            grp_cnt <= '0;
                            pt_cnt  <= pt_cnt + 1'b1;
                            state   <= S_MAP_REQ;
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Configuration and map word
    always_ff @(posedge clk) begin
        if (cfg_hs) begin
            k_q          <= cfg_k;
            num_points_q <= cfg_num_points;
            num_grp_q    <= cfg_num_grp;
            out_base_q   <= cfg_out_base;
        end
        if (map_rsp) begin
            map_word <= map_port.rsp_dat;
        end
    end

    lane_max u_lane_max (
        .clk     ( clk                          ),
        .rst_n   ( rst_n                        ),
        .load    ( row_strb && (nb_cnt == '0)   ),
        .update  ( row_strb && (nb_cnt != '0)   ),
        .row_in  ( ofm_rd_dat                   ),
        .row_max ( row_max                      )
    );

endmodule

//--- design/core_arbiter.sv
//==========================================================================
// Round-robin arbiter from NUM_CORE core ports onto one memory port
// The granted request reaches the top port in the same cycle. With
// RETURN_EN the granted index is queued and each reply strobe is steered
// to the core at the head of the queue.
//==========================================================================
`timescale 1ns/1ns

module core_arbiter #(
    parameter int NUM_CORE  = 4,
    parameter int DAT_WIDTH = 128,
    parameter bit RETURN_EN = 1'b1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    core_port_if.arb             ports [NUM_CORE],
    output logic                 top_vld,
    output pool_bus_pkg::idx_t   top_addr,
    output logic [DAT_WIDTH-1:0] top_dat,
    input  logic                 top_rdy,
    input  logic                 rsp_vld,
    input  logic [DAT_WIDTH-1:0] rsp_dat
);

    import pool_bus_pkg::*;

    localparam int SEL_W = (NUM_CORE > 1) ? $clog2(NUM_CORE) : 1;

    logic [NUM_CORE-1:0]                req_vld_a;
    idx_t [NUM_CORE-1:0]                req_addr_a;
    logic [NUM_CORE-1:0][DAT_WIDTH-1:0] req_dat_a;
    logic [NUM_CORE-1:0]                rsp_hit;
    logic [SEL_W-1:0]                   rr_ptr;
    logic [SEL_W-1:0]                   sel;
    logic                               top_hs;

    // Wraps at NUM_CORE, also for counts that are not a power of two
    function automatic logic [SEL_W-1:0] ptr_inc(input logic [SEL_W-1:0] p);
        return (p == SEL_W'(NUM_CORE - 1)) ? '0 : p + 1'b1;
    endfunction

    //======================================================================
    // Port gathering and reply fan-out
    //======================================================================
    for (genvar i = 0; i < NUM_CORE; i++) begin : g_port
        assign req_vld_a[i]     = ports[i].req_vld;
        assign req_addr_a[i]    = ports[i].req_addr;
        assign req_dat_a[i]     = ports[i].req_dat;
        assign ports[i].req_rdy = top_rdy && (sel == SEL_W'(i));
        assign ports[i].rsp_vld = rsp_hit[i];
        assign ports[i].rsp_dat = rsp_dat;
    end

    //======================================================================
    // Grant
    //======================================================================
    // First requester at or after the pointer, lowest offset wins
    always_comb begin
        int idx;
        sel = rr_ptr;
        for (int i = NUM_CORE - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NUM_CORE;
            if (req_vld_a[idx]) begin
                sel = SEL_W'(idx);
            end
        end
    end

    assign top_vld  = |req_vld_a;
    assign top_addr = req_addr_a[sel];
    assign top_dat  = req_dat_a[sel];
    assign top_hs   = top_vld && top_rdy;

    // Lock onto a waiting grant, move past it once accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (top_hs) begin
            rr_ptr <= ptr_inc(sel);
        end else if (top_vld) begin
            rr_ptr <= sel;
        end
    end

    //======================================================================
    // In-order reply routing
    //======================================================================
    if (RETURN_EN) begin : g_ret
        // One outstanding request per core bounds the depth
        logic [SEL_W-1:0] queue [NUM_CORE];
        logic [SEL_W-1:0] wr_ptr;
        logic [SEL_W-1:0] rd_ptr;
        logic [SEL_W-1:0] head;

        assign head    = queue[rd_ptr];
        assign rsp_hit = NUM_CORE'(rsp_vld) << head;

        always_ff @(posedge clk) begin
            if (top_hs) begin
                queue[wr_ptr] <= sel;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (top_hs) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (rsp_vld) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
            end
        end
    end else begin : g_no_ret
        assign rsp_hit = '0;
    end

endmodule

//--- design/pool_top.sv
//==========================================================================
// Max-pooling engine top level
// NUM_CORE pool cores share one map read port through u_map_arb and one
// output write port through u_wr_arb. Each core has its own feature read
// port and its own configuration handshake.
//==========================================================================
`timescale 1ns/1ns

module pool_top #(
    parameter int NUM_CORE = pool_geom_pkg::NUM_CORE_DEF
) (
    input  logic                                             clk,
    input  logic                                             rst_n,
    // Per-core configuration
    input  logic [NUM_CORE-1:0]                              cfg_vld,
    output logic [NUM_CORE-1:0]                              cfg_rdy,
    input  logic [NUM_CORE-1:0][pool_geom_pkg::K_WIDTH-1:0]   cfg_k,
    input  pool_bus_pkg::idx_t [NUM_CORE-1:0]                cfg_num_points,
    input  logic [NUM_CORE-1:0][pool_geom_pkg::GRP_WIDTH-1:0] cfg_num_grp,
    input  pool_bus_pkg::idx_t [NUM_CORE-1:0]                cfg_out_base,
    // Shared map memory
    output logic                                             map_rd_vld,
    output pool_bus_pkg::idx_t                               map_rd_addr,
    input  logic                                             map_rd_rdy,
    input  logic                                             map_rd_dat_vld,
    input  pool_bus_pkg::map_word_t                          map_rd_dat,
    // Per-core feature memory
    output logic [NUM_CORE-1:0]                              ofm_rd_vld,
    output pool_bus_pkg::idx_t [NUM_CORE-1:0]                ofm_rd_addr,
    input  logic [NUM_CORE-1:0]                              ofm_rd_rdy,
    input  logic [NUM_CORE-1:0]                              ofm_rd_dat_vld,
    input  pool_bus_pkg::act_row_t [NUM_CORE-1:0]            ofm_rd_dat,
    // Shared output write port
    output logic                                             ofm_wr_vld,
    output pool_bus_pkg::idx_t                               ofm_wr_addr,
    output pool_bus_pkg::act_row_t                           ofm_wr_dat,
    input  logic                                             ofm_wr_rdy
);

    import pool_bus_pkg::*;

    localparam int MAP_DW = $bits(map_word_t);
    localparam int ROW_DW = $bits(act_row_t);

    core_port_if #(.DAT_WIDTH(MAP_DW)) map_if [NUM_CORE] ();
    core_port_if #(.DAT_WIDTH(ROW_DW)) wr_if  [NUM_CORE] ();

    // Map reads, replies routed back in request order
    core_arbiter #(
        .NUM_CORE  ( NUM_CORE ),
        .DAT_WIDTH ( MAP_DW   ),
        .RETURN_EN ( 1'b1     )
    ) u_map_arb (
        .clk      ( clk            ),
        .rst_n    ( rst_n          ),
        .ports    ( map_if         ),
        .top_vld  ( map_rd_vld     ),
        .top_addr ( map_rd_addr    ),
        .top_dat  (                ),
        .top_rdy  ( map_rd_rdy     ),
        .rsp_vld  ( map_rd_dat_vld ),
        .rsp_dat  ( map_rd_dat     )
    );

    // Pooled results, no reply path
    core_arbiter #(
        .NUM_CORE  ( NUM_CORE ),
        .DAT_WIDTH ( ROW_DW   ),
        .RETURN_EN ( 1'b0     )
    ) u_wr_arb (
        .clk      ( clk         ),
        .rst_n    ( rst_n       ),
        .ports    ( wr_if       ),
        .top_vld  ( ofm_wr_vld  ),
        .top_addr ( ofm_wr_addr ),
        .top_dat  ( ofm_wr_dat  ),
        .top_rdy  ( ofm_wr_rdy  ),
        .rsp_vld  ( 1'b0        ),
        .rsp_dat  ( '0          )
    );

    for (genvar i = 0; i < NUM_CORE; i++) begin : g_core
        pool_core u_core (
            .clk            ( clk               ),
            .rst_n          ( rst_n             ),
            .cfg_vld        ( cfg_vld[i]        ),
            .cfg_rdy        ( cfg_rdy[i]        ),
            .cfg_k          ( cfg_k[i]          ),
            .cfg_num_points ( cfg_num_points[i] ),
            .cfg_num_grp    ( cfg_num_grp[i]    ),
            .cfg_out_base   ( cfg_out_base[i]   ),
            .map_port       ( map_if[i]         ),
            .wr_port        ( wr_if[i]          ),
            .ofm_rd_vld     ( ofm_rd_vld[i]     ),
            .ofm_rd_addr    ( ofm_rd_addr[i]    ),
            .ofm_rd_rdy     ( ofm_rd_rdy[i]     ),
            .ofm_rd_dat_vld ( ofm_rd_dat_vld[i] ),
            .ofm_rd_dat     ( ofm_rd_dat[i]     )
        );
    end

endmodule

//--- sim/pool_tb.sv
//============================================================================
// Random testbench for the max-pooling engine
// Models the map memory, four feature memories and the output write port,
// computes every pooled row in a reference model and checks each write.
//============================================================================
`timescale 1ns/1ns

module pool_tb;

    import pool_geom_pkg::*;
    import pool_bus_pkg::*;

    localparam int NCORE      = 4;
    localparam int MAX_PTS    = 6;
    localparam int MAX_GRP    = 4;
    localparam int MAP_DEPTH  = 8;
    localparam int FEAT_DEPTH = 64;
    // Upper bound on writes over all tests
    localparam int MAX_WRITES = 12 + (3 * NCORE + 1) * MAX_PTS * MAX_GRP;
    // Each write is allowed 200 cycles
    localparam int WATCHDOG_CYC = MAX_WRITES * 200;

    logic                              clk;
    logic                              rst_n;
    logic [NCORE-1:0]                  cfg_vld;
    logic [NCORE-1:0]                  cfg_rdy;
    logic [NCORE-1:0][K_WIDTH-1:0]     cfg_k;
    idx_t [NCORE-1:0]                  cfg_num_points;
    logic [NCORE-1:0][GRP_WIDTH-1:0]   cfg_num_grp;
    idx_t [NCORE-1:0]                  cfg_out_base;
    logic                              map_rd_vld;
    idx_t                              map_rd_addr;
    logic                              map_rd_rdy;
    logic                              map_rd_dat_vld;
    map_word_t                         map_rd_dat;
    logic [NCORE-1:0]                  ofm_rd_vld;
    idx_t [NCORE-1:0]                  ofm_rd_addr;
    logic [NCORE-1:0]                  ofm_rd_rdy;
    logic [NCORE-1:0]                  ofm_rd_dat_vld;
    act_row_t [NCORE-1:0]              ofm_rd_dat;
    logic                              ofm_wr_vld;
    idx_t                              ofm_wr_addr;
    act_row_t                          ofm_wr_dat;
    logic                              ofm_wr_rdy;

    integer    seed = 5;
    map_word_t map_mem [MAP_DEPTH];
    act_row_t  feat_mem [FEAT_DEPTH];

    // Expected results by write address
    act_row_t  exp_mem [int];
    int        exp_core [int];
    bit        got [int];
    int        cfg_cnt [NCORE];
    int        rem [NCORE];

    // Memory model state
    int        cyc;
    int        map_addr_q [$];
    int        map_due_q [$];
    bit        map_hs_q;
    int        map_hs_addr;
    int        due;
    bit        feat_hs_q [NCORE];
    int        feat_hs_addr [NCORE];
    bit        feat_pend [NCORE];
    int        feat_addr [NCORE];
    int        feat_due [NCORE];
    bit        bp_en;
    bit        hold_vld;
    idx_t      hold_addr;
    act_row_t  hold_dat;
    int        wa;

    int        errors;
    int        err_mark;
    int        writes;
    int        passed;
    int        failed;

    pool_top #(.NUM_CORE(NCORE)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Test failures found");
        $finish;
    end

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    //========================================================================
    // Checks at the falling edge where handshakes have settled
    //========================================================================
    always @(negedge clk) begin
        for (int c = 0; c < NCORE; c++) begin
            assert (!(cfg_rdy[c] && rem[c] != 0)) else begin
                $display("Error: cfg_rdy[%0d]=%h with %0d writes outstanding, expected 0",
                         c, cfg_rdy[c], rem[c]);
                errors++;
            end
            if (cfg_vld[c] && cfg_rdy[c]) begin
                rem[c] = cfg_cnt[c];
            end
            feat_hs_q[c] = ofm_rd_vld[c] && ofm_rd_rdy[c];
            feat_hs_addr[c] = 0;
            if (feat_hs_q[c]) begin
                assert (ofm_rd_addr[c] < FEAT_DEPTH) else begin
                    $display("Error: ofm_rd_addr[%0d]=%h is beyond the feature memory",
                             c, ofm_rd_addr[c]);
                    errors++;
                end
                feat_hs_addr[c] = ofm_rd_addr[c] % FEAT_DEPTH;
            end
        end
        map_hs_q = map_rd_vld && map_rd_rdy;
        map_hs_addr = map_rd_addr % MAP_DEPTH;
        if (map_hs_q) begin
            assert (map_rd_addr < MAP_DEPTH) else begin
                $display("Error: map_rd_addr=%h is beyond the map memory", map_rd_addr);
                errors++;
            end
        end
        // Held write must not change under back-pressure
        if (hold_vld) begin
            assert (ofm_wr_vld && ofm_wr_addr == hold_addr && ofm_wr_dat == hold_dat) else begin
                $display({"Error: held write changed, ofm_wr_vld=%h ofm_wr_addr=%h ",
                          "ofm_wr_dat=%h, expected 1, %h, %h"},
                         ofm_wr_vld, ofm_wr_addr, ofm_wr_dat, hold_addr, hold_dat);
                errors++;
            end
        end
        hold_vld  = ofm_wr_vld && !ofm_wr_rdy;
        hold_addr = ofm_wr_addr;
        hold_dat  = ofm_wr_dat;
        if (ofm_wr_vld && ofm_wr_rdy) begin
            wa = ofm_wr_addr;
            writes++;
            assert (exp_mem.exists(wa)) else begin
                $display("Write to address %h that no core should produce", wa);
                errors++;
            end
            if (exp_mem.exists(wa)) begin
                assert (!got[wa]) else begin
                    $display("Address %h was written more than once", wa);
                    errors++;
                end
                assert (ofm_wr_dat == exp_mem[wa]) else begin
                    $display("Error: ofm_wr_dat at ofm_wr_addr %h is %h, expected %h",
                             wa, ofm_wr_dat, exp_mem[wa]);
                    errors++;
                end
                got[wa] = 1'b1;
                rem[exp_core[wa]]--;
            end
        end
    end

    //========================================================================
    // Memory models drive 1 ns after the rising edge
    //========================================================================
    always @(posedge clk) begin
        #1;
        cyc++;
        // Map replies come in request order 1 to 4 cycles late
        if (map_hs_q) begin
            due = cyc + rnd(4);
            if (map_due_q.size() > 0 && due <= map_due_q[$]) begin
                due = map_due_q[$] + 1;
            end
            map_addr_q.push_back(map_hs_addr);
            map_due_q.push_back(due);
        end
        map_rd_dat_vld = 1'b0;
        if (map_due_q.size() > 0 && map_due_q[0] == cyc) begin
            map_rd_dat_vld = 1'b1;
            map_rd_dat = map_mem[map_addr_q.pop_front()];
            void'(map_due_q.pop_front());
        end
        map_rd_rdy = (rnd(4) != 0);
        for (int c = 0; c < NCORE; c++) begin
            if (feat_hs_q[c]) begin
                feat_pend[c] = 1'b1;
                feat_addr[c] = feat_hs_addr[c];
                feat_due[c]  = cyc + rnd(3);
            end
            ofm_rd_dat_vld[c] = 1'b0;
            if (feat_pend[c] && feat_due[c] == cyc) begin
                ofm_rd_dat_vld[c] = 1'b1;
                ofm_rd_dat[c]     = feat_mem[feat_addr[c]];
                feat_pend[c]      = 1'b0;
            end
            ofm_rd_rdy[c] = (rnd(3) != 0);
        end
        ofm_wr_rdy = bp_en ? (rnd(2) != 0) : 1'b1;
    end

    //========================================================================
    // Test sequencing
    //========================================================================
    // Reference pooling for one core before its configuration is presented
    task automatic load_core(input int c, input int k, input int np, input int ng,
                             input int base);
        act_row_t row;
        act_row_t cand;
        int       a;
        for (int p = 0; p < np; p++) begin
            for (int g = 0; g < ng; g++) begin
                row = feat_mem[map_mem[p][0] * ng + g];
                for (int n = 1; n < k; n++) begin
                    cand = feat_mem[map_mem[p][n] * ng + g];
                    for (int l = 0; l < LANES; l++) begin
                        if (cand[l] > row[l]) row[l] = cand[l];
                    end
                end
                a = base + p * ng + g;
                exp_mem[a]  = row;
                exp_core[a] = c;
                got[a]      = 1'b0;
            end
        end
        cfg_cnt[c]        = np * ng;
        cfg_k[c]          = K_WIDTH'(k);
        cfg_num_points[c] = idx_t'(np);
        cfg_num_grp[c]    = GRP_WIDTH'(ng);
        cfg_out_base[c]   = idx_t'(base);
        cfg_vld[c]        = 1'b1;
    endtask

    task automatic send_cfg();
        do @(negedge clk); while ((cfg_vld & ~cfg_rdy) != '0);
        @(posedge clk);
        #1;
        cfg_vld = '0;
    endtask

    // All cores back in idle marks the end of a run
    task automatic wait_idle();
        do @(negedge clk); while (cfg_rdy != '1);
        @(posedge clk);
        #1;
    endtask

    task automatic start_test();
        exp_mem.delete();
        exp_core.delete();
        got.delete();
        err_mark = errors;
    endtask

    task automatic finish_test(input string name);
        foreach (exp_mem[a]) begin
            assert (got[a]) else begin
                $display("Expected address %h was never written", a);
                errors++;
            end
        end
        if (errors == err_mark) begin
            $display("PASS  %s", name);
            passed++;
        end else begin
            $display("FAIL  %s, %0d errors", name, errors - err_mark);
            failed++;
        end
        err_mark = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        cfg_vld = '0;
        cfg_k = '0;
        cfg_num_points = '0;
        cfg_num_grp = '0;
        cfg_out_base = '0;
        map_rd_rdy = 1'b0;
        map_rd_dat_vld = 1'b0;
        map_rd_dat = '0;
        ofm_rd_rdy = '0;
        ofm_rd_dat_vld = '0;
        ofm_rd_dat = '0;
        ofm_wr_rdy = 1'b0;
        bp_en = 1'b0;
        for (int p = 0; p < MAP_DEPTH; p++) begin
            for (int n = 0; n < MAX_K; n++) map_mem[p][n] = idx_t'(rnd(16));
        end
        for (int i = 0; i < FEAT_DEPTH; i++) begin
            for (int l = 0; l < LANES; l++) feat_mem[i][l] = ACT_WIDTH'(rnd(256));
        end
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test();
        @(negedge clk);
        assert (cfg_rdy == '1 && !map_rd_vld && ofm_rd_vld == '0 && !ofm_wr_vld) else begin
            $display("Error: after reset cfg_rdy=%h map_rd_vld=%h ofm_rd_vld=%h ofm_wr_vld=%h",
                     cfg_rdy, map_rd_vld, ofm_rd_vld, ofm_wr_vld);
            errors++;
        end
        @(posedge clk);
        #1;
        finish_test("reset values");

        start_test();
        load_core(0, 1, 4, 3, 16'h0100);
        send_cfg();
        wait_idle();
        finish_test("single core, K of 1");

        start_test();
        for (int c = 0; c < NCORE; c++) begin
            load_core(c, 1 + rnd(MAX_K), 1 + rnd(MAX_PTS), 1 + rnd(MAX_GRP), c * 16'h0400);
        end
        send_cfg();
        wait_idle();
        finish_test("all cores, random K");

        start_test();
        bp_en = 1'b1;
        for (int c = 0; c < NCORE; c++) begin
            load_core(c, 1 + rnd(MAX_K), 1 + rnd(MAX_PTS), 1 + rnd(MAX_GRP), c * 16'h0400);
        end
        send_cfg();
        wait_idle();
        finish_test("write back-pressure");

        // Core 2 is configured again while the others may still run
        start_test();
        for (int c = 0; c < NCORE; c++) begin
            load_core(c, 1 + rnd(MAX_K), 1 + rnd(MAX_PTS), 1 + rnd(MAX_GRP), c * 16'h0400);
        end
        send_cfg();
        do @(negedge clk); while (!cfg_rdy[2]);
        @(posedge clk);
        #1;
        load_core(2, 1 + rnd(MAX_K), 1 + rnd(MAX_PTS), 1 + rnd(MAX_GRP), 16'h2000);
        send_cfg();
        wait_idle();
        finish_test("reconfiguration after done");

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d writes checked, %0d errors",
                 passed + failed, passed, failed, writes, errors);
        if (failed == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/pool_geom_pkg.sv
common/pool_bus_pkg.sv
common/core_port_if.sv
pool_core/lane_max.sv
pool_core/pool_core.sv
design/core_arbiter.sv
design/pool_top.sv
sim/pool_tb.sv
